// ==== design/boot_copier.sv ====
// boot-time copy of a fixed flash block into RAM
// streams BOOT_WORDS words in continue mode and writes each with a full wstrb
// dma_busy holds the bus from reset until the last write has gone out

`timescale 1ns/1ps
`default_nettype none

module boot_copier (
    input  wire logic                        clk,
    input  wire logic                        reset,
    output logic                             req_valid,
    output flash_map_pkg::flash_addr_t       req_addr,
    input  wire logic                        req_ready,
    input  wire spi_flash_pkg::flash_word_t  rdata,
    output flash_map_pkg::ram_addr_t         write_address,
    output spi_flash_pkg::flash_word_t       write_data,
    output logic [3:0]                       wstrb,
    output logic                             dma_busy
);

    // words received so far
    logic [13:0] word_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid     <= 1'b1;
            req_addr      <= flash_map_pkg::BOOT_LOAD_BASE;
            word_count    <= '0;
            write_address <= flash_map_pkg::BOOT_WRITE_BASE;
            wstrb         <= 4'b0000;
            dma_busy      <= 1'b1;
        end else begin
            wstrb <= 4'b0000;

            // post-increment once the write cycle is over
            if (wstrb[0]) begin
                write_address <= write_address + 32'd1;
            end

            if (req_valid && req_ready) begin
                wstrb      <= 4'b1111;
                word_count <= word_count + 14'd1;
                // last word, let the reader release the chip
                if (word_count == flash_map_pkg::BOOT_WORDS - 14'd1) begin
                    req_valid <= 1'b0;
                end else begin
                    req_addr <= req_addr + 24'd4;
                end
            end

            // hand the bus back once the final strobe has been issued
            if (!req_valid && wstrb == 4'b0000) begin
                dma_busy <= 1'b0;
            end
        end
    end

    // capture the word alongside the strobe
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            write_data <= rdata;
        end
    end

endmodule

`default_nettype wire

// ==== design/cpu_flash_port.sv ====
// CPU random read port into the flash user area
// a rising edge on read_en posts one word read, the CPU stalls until read_ready

`timescale 1ns/1ps
`default_nettype none

module cpu_flash_port (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       read_en,
    input  wire flash_map_pkg::cpu_addr_t   read_address,
    output logic                            read_ready,
    output logic                            req_valid,
    output flash_map_pkg::flash_addr_t      req_addr,
    input  wire logic                       req_ready
);

    // read_en registered twice, first stage for timing, second for the edge
    logic read_en_r;
    logic read_en_d;
    logic start;

    // only a new edge starts a read, and only while nothing is pending
    assign start = read_en_r && !read_en_d && !req_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            read_en_r  <= 1'b0;
            read_en_d  <= 1'b0;
            req_valid  <= 1'b0;
            read_ready <= 1'b0;
        end else begin
            read_en_r <= read_en;
            read_en_d <= read_en_r;

            if (start) begin
                req_valid <= 1'b1;
            end else if (req_ready) begin
                req_valid <= 1'b0;
            end

            // release the CPU, read_data is already held by the reader
            read_ready <= req_valid && req_ready;
        end
    end

    // offset is relative to the start of the user area
    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= flash_map_pkg::FLASH_USER_BASE +
                        flash_map_pkg::flash_addr_t'(read_address);
        end
    end

endmodule

`default_nettype wire

// ==== design/flash_arbiter.sv ====
// shares the one flash reader between the boot copier and the CPU port
// boot owns the reader while busy; ownership moves only between words

`timescale 1ns/1ps
`default_nettype none

module flash_arbiter (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       boot_busy,
    input  wire logic                       boot_valid,
    input  wire flash_map_pkg::flash_addr_t boot_addr,
    output logic                            boot_ready,
    input  wire logic                       cpu_valid,
    input  wire flash_map_pkg::flash_addr_t cpu_addr,
    output logic                            cpu_ready,
    output logic                            flash_valid,
    output flash_map_pkg::flash_addr_t      flash_addr,
    output logic                            flash_continue,
    input  wire logic                       flash_ready
);

    logic owner_boot;

    // owner's valid low means no word is in flight at the reader
    always_ff @(posedge clk) begin
        if (reset) begin
            owner_boot <= 1'b1;
        end else if (!flash_valid) begin
            owner_boot <= boot_busy;
        end
    end

    assign flash_valid    = owner_boot ? boot_valid : cpu_valid;
    assign flash_addr     = owner_boot ? boot_addr : cpu_addr;
    // sequential streaming only for the boot block
    assign flash_continue = owner_boot;

    // a waiting CPU read never sees a boot word
    assign boot_ready = owner_boot && flash_ready;
    assign cpu_ready  = !owner_boot && flash_ready;

endmodule

`default_nettype wire

// ==== design/flash_dma.sv ====
// flash DMA top: boot copy into RAM after reset, then CPU reads from flash
// boot copier and CPU port share the SPI reader through the arbiter

`timescale 1ns/1ps
`default_nettype none

module flash_dma (
    input  wire logic                       clk,
    input  wire logic                       reset,
    // CPU reads, read_ready ends the stall
    input  wire flash_map_pkg::cpu_addr_t   read_address,
    output spi_flash_pkg::flash_word_t      read_data,
    input  wire logic                       read_en,
    output logic                            read_ready,
    // RAM writes during boot
    output flash_map_pkg::ram_addr_t        write_address,
    output spi_flash_pkg::flash_word_t      write_data,
    output logic [3:0]                      wstrb,
    output logic                            dma_busy,
    // SPI flash pins
    output logic                            flash_sck,
    output logic                            flash_csn,
    output logic                            flash_mosi,
    input  wire logic                       flash_miso
);

    logic                       boot_valid;
    logic                       boot_ready;
    flash_map_pkg::flash_addr_t boot_addr;
    logic                       cpu_valid;
    logic                       cpu_ready;
    flash_map_pkg::flash_addr_t cpu_addr;
    logic                       flash_valid;
    logic                       flash_ready;
    logic                       flash_continue;
    flash_map_pkg::flash_addr_t flash_addr;
    spi_flash_pkg::flash_word_t flash_rdata;

    // reader holds rdata until the next word, so the CPU sees it directly
    assign read_data = flash_rdata;

    boot_copier boot (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (boot_valid),
        .req_addr      (boot_addr),
        .req_ready     (boot_ready),
        .rdata         (flash_rdata),
        .write_address (write_address),
        .write_data    (write_data),
        .wstrb         (wstrb),
        .dma_busy      (dma_busy)
    );

    cpu_flash_port cpu_port (
        .clk          (clk),
        .reset        (reset),
        .read_en      (read_en),
        .read_address (read_address),
        .read_ready   (read_ready),
        .req_valid    (cpu_valid),
        .req_addr     (cpu_addr),
        .req_ready    (cpu_ready)
    );

    flash_arbiter arbiter (
        .clk            (clk),
        .reset          (reset),
        .boot_busy      (dma_busy),
        .boot_valid     (boot_valid),
        .boot_addr      (boot_addr),
        .boot_ready     (boot_ready),
        .cpu_valid      (cpu_valid),
        .cpu_addr       (cpu_addr),
        .cpu_ready      (cpu_ready),
        .flash_valid    (flash_valid),
        .flash_addr     (flash_addr),
        .flash_continue (flash_continue),
        .flash_ready    (flash_ready)
    );

    spi_flash_reader reader (
        .clk              (clk),
        .reset            (reset),
        .valid            (flash_valid),
        .continue_reading (flash_continue),
        .addr             (flash_addr),
        .ready            (flash_ready),
        .rdata            (flash_rdata),
        .flash_csn        (flash_csn),
        .flash_sck        (flash_sck),
        .flash_mosi       (flash_mosi),
        .flash_miso       (flash_miso)
    );

endmodule

`default_nettype wire

// ==== design/flash_map_pkg.sv ====
// address map shared by the boot copier, the CPU read port and the flash model
// flash addresses are byte addresses, RAM addresses are word addresses
// files refer to these through flash_map_pkg:: scoped names

`default_nettype none

package flash_map_pkg;

    // 16 MB serial flash, byte addressed
    typedef logic [23:0] flash_addr_t;
    // RAM is addressed in 32-bit words
    typedef logic [31:0] ram_addr_t;
    // CPU offset into the user area, word aligned
    typedef logic [17:0] cpu_addr_t;

    // user data sits above the first megabyte
    localparam flash_addr_t FLASH_USER_BASE = 24'h100000;

    // boot image copied into RAM after reset
    localparam flash_addr_t BOOT_LOAD_BASE  = 24'h100000;
    localparam ram_addr_t   BOOT_WRITE_BASE = 32'h0000_0000;
    localparam logic [13:0] BOOT_WORDS      = 14'd16;

endpackage

`default_nettype wire

// ==== design/spi_flash_pkg.sv ====
// SPI flash protocol definitions used by the serial reader and the flash model
// words are assembled little-endian, first byte on the wire lands in bits 7:0

`default_nettype none

package spi_flash_pkg;

    // one 32-bit word as returned to the requesters
    typedef logic [31:0] flash_word_t;

    // bits left in the current command, address or data field
    typedef logic [5:0] bit_count_t;

    // plain serial read, no dummy cycles
    localparam logic [7:0] SPI_READ_CMD = 8'h03;

    // serial reader FSM
    typedef enum logic [2:0] {
        RD_IDLE,
        RD_COMMAND,
        RD_ADDRESS,
        RD_DATA,
        RD_DONE
    } reader_state_t;

endpackage

`default_nettype wire

// ==== design/spi_flash_reader.sv ====
// single-lane SPI flash read controller, mode 0, sck at half the clock rate
// valid/addr start a read, ready pulses once per 32-bit word with rdata
// with continue_reading high the chip stays selected and words keep streaming

`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       valid,
    input  wire logic                       continue_reading,
    input  wire flash_map_pkg::flash_addr_t addr,
    output logic                            ready,
    output spi_flash_pkg::flash_word_t      rdata,
    output logic                            flash_csn,
    output logic                            flash_sck,
    output logic                            flash_mosi,
    input  wire logic                       flash_miso
);

    spi_flash_pkg::reader_state_t state;
    spi_flash_pkg::bit_count_t    bit_cnt;
    spi_flash_pkg::flash_word_t   shift_in;
    logic [31:0]                  shift_out;

    // command and address go out MSB first
    assign flash_mosi = shift_out[31];

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= spi_flash_pkg::RD_IDLE;
            bit_cnt   <= '0;
            shift_out <= '0;
            ready     <= 1'b0;
            flash_csn <= 1'b1;
            flash_sck <= 1'b0;
        end else begin
            ready <= 1'b0;
            if (!valid && (state == spi_flash_pkg::RD_COMMAND ||
                           state == spi_flash_pkg::RD_ADDRESS ||
                           state == spi_flash_pkg::RD_DATA)) begin
                // requester withdrew, release the chip mid-transfer
                state     <= spi_flash_pkg::RD_IDLE;
                flash_csn <= 1'b1;
                flash_sck <= 1'b0;
            end else begin
                case (state)
                    spi_flash_pkg::RD_IDLE: begin
                        flash_csn <= 1'b1;
                        flash_sck <= 1'b0;
                        // ready high means this valid belongs to the word just returned
                        if (valid && !ready) begin
                            flash_csn <= 1'b0;
                            shift_out <= {spi_flash_pkg::SPI_READ_CMD, addr};
                            bit_cnt   <= 6'd7;
                            state     <= spi_flash_pkg::RD_COMMAND;
                        end
                    end
                    spi_flash_pkg::RD_COMMAND: begin
                        flash_sck <= !flash_sck;
                        // shift on the falling edge, flash samples on the rising one
                        if (flash_sck) begin
                            shift_out <= {shift_out[30:0], 1'b0};
                            if (bit_cnt == 6'd0) begin
                                bit_cnt <= 6'd23;
                                state   <= spi_flash_pkg::RD_ADDRESS;
                            end else begin
                                bit_cnt <= bit_cnt - 6'd1;
                            end
                        end
                    end
                    spi_flash_pkg::RD_ADDRESS: begin
                        flash_sck <= !flash_sck;
                        if (flash_sck) begin
                            shift_out <= {shift_out[30:0], 1'b0};
                            // last falling edge also makes the flash drive data bit 0
                            if (bit_cnt == 6'd0) begin
                                bit_cnt <= 6'd31;
                                state   <= spi_flash_pkg::RD_DATA;
                            end else begin
                                bit_cnt <= bit_cnt - 6'd1;
                            end
                        end
                    end
                    spi_flash_pkg::RD_DATA: begin
                        flash_sck <= !flash_sck;
                        if (flash_sck) begin
                            if (bit_cnt == 6'd0) begin
                                state <= spi_flash_pkg::RD_DONE;
                            end else begin
                                bit_cnt <= bit_cnt - 6'd1;
                            end
                        end
                    end
                    spi_flash_pkg::RD_DONE: begin
                        ready <= 1'b1;
                        // sequential mode, flash already holds the next bit on miso
                        if (continue_reading && valid) begin
                            bit_cnt <= 6'd31;
                            state   <= spi_flash_pkg::RD_DATA;
                        end else begin
                            flash_csn <= 1'b1;
                            state     <= spi_flash_pkg::RD_IDLE;
                        end
                    end
                    default: begin
                        state <= spi_flash_pkg::RD_IDLE;
                    end
                endcase
            end
        end
    end

    // data path, miso sampled while sck is high and before it falls
    always_ff @(posedge clk) begin
        if (state == spi_flash_pkg::RD_DATA && flash_sck && valid) begin
            shift_in <= {shift_in[30:0], flash_miso};
        end
        // byte swap so the first byte received ends up in bits 7:0
        if (state == spi_flash_pkg::RD_DONE) begin
            rdata <= {shift_in[7:0], shift_in[15:8], shift_in[23:16], shift_in[31:24]};
        end
    end

endmodule

`default_nettype wire

// ==== flash_dma.f ====
design/flash_map_pkg.sv
design/spi_flash_pkg.sv
design/spi_flash_reader.sv
design/boot_copier.sv
design/cpu_flash_port.sv
design/flash_arbiter.sv
design/flash_dma.sv
verification/spi_flash_model.sv
verification/flash_dma_checker.sv
verification/flash_dma_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile flash_dma_tb with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module flash_dma_tb -f flash_dma.f \
    -o flash_dma_sim > build.log 2>&1 \
    && ./obj_dir/flash_dma_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -qx "=== PASS ===" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verification/flash_dma_checker.sv ====
// watches the flash DMA ports and compares them against the flash pattern
// checks the reset state, every boot RAM write, the end of boot and CPU reads
// error_count and check_count are read by the testbench top for its summary

`timescale 1ns/1ps
`default_nettype none

module flash_dma_checker (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       dma_busy,
    input  wire logic [3:0]                 wstrb,
    input  wire flash_map_pkg::ram_addr_t   write_address,
    input  wire spi_flash_pkg::flash_word_t write_data,
    input  wire logic                       read_en,
    input  wire logic                       read_ready,
    input  wire spi_flash_pkg::flash_word_t read_data,
    input  wire logic                       flash_csn,
    input  wire logic                       flash_sck,
    // word the current CPU read must return
    input  wire spi_flash_pkg::flash_word_t expected_word,
    output int                              error_count,
    output int                              check_count
);

    int          errors = 0;
    int          checks = 0;
    // rising edges of read_en not yet answered by read_ready
    int          reads_pending = 0;
    logic [13:0] write_index = 14'd0;
    logic        reset_q = 1'b0;
    logic        busy_q = 1'b0;
    logic        read_en_q = 1'b0;

    assign error_count = errors;
    assign check_count = checks;

    // little-endian word where byte n holds the folded address a+n xor A5
    function automatic spi_flash_pkg::flash_word_t pattern_word(
        input flash_map_pkg::flash_addr_t a
    );
        spi_flash_pkg::flash_word_t w;
        flash_map_pkg::flash_addr_t b;
        for (int i = 0; i < 4; i++) begin
            b = a + 24'(i);
            w[8*i +: 8] = b[23:16] ^ b[15:8] ^ b[7:0] ^ 8'hA5;
        end
        return w;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic note_failure(input string what);
        errors = errors + 1;
        $display("%s at %0d ns", what, $time);
    endtask

    // DUT outputs change on the rising edge and are sampled here half a cycle later
    always @(negedge clk) begin
        if (!reset) begin
            // first sample after reset still shows the reset values
            if (reset_q) begin
                compare("dma_busy", 32'd1, 32'(dma_busy));
                compare("wstrb", 32'd0, 32'(wstrb));
                compare("read_ready", 32'd0, 32'(read_ready));
                compare("flash_csn", 32'd1, 32'(flash_csn));
                compare("flash_sck", 32'd0, 32'(flash_sck));
            end
            if (wstrb != 4'b0000) begin
                if (write_index >= flash_map_pkg::BOOT_WORDS) begin
                    note_failure("RAM write seen after the boot block was complete");
                end else begin
                    compare("wstrb", 32'hf, 32'(wstrb));
                    compare("write_address",
                            flash_map_pkg::BOOT_WRITE_BASE + 32'(write_index), write_address);
                    compare("write_data",
                            pattern_word(flash_map_pkg::BOOT_LOAD_BASE +
                                         24'({write_index, 2'b00})), write_data);
                    write_index = write_index + 14'd1;
                end
            end
            // busy may only drop once the whole block is written
            if (busy_q && !dma_busy) begin
                checks = checks + 1;
                if (write_index != flash_map_pkg::BOOT_WORDS) begin
                    note_failure($sformatf("dma_busy fell after only %0d RAM writes",
                                           write_index));
                end
            end
            if (read_en && !read_en_q) begin
                reads_pending = reads_pending + 1;
            end
            if (read_ready) begin
                if (reads_pending == 0) begin
                    note_failure("read_ready pulsed without a new rising edge on read_en");
                end else begin
                    reads_pending = reads_pending - 1;
                end
                if (dma_busy) begin
                    note_failure("CPU read completed while the boot copy still held the bus");
                end
                compare("read_data", expected_word, read_data);
            end
        end
        reset_q   = reset;
        busy_q    = dma_busy;
        read_en_q = read_en;
    end

endmodule

`default_nettype wire

// ==== verification/flash_dma_tb.sv ====
// top testbench for flash_dma with a serial flash model and a checker
// runs the boot copy and then a table of CPU reads with the first one posted during boot
// prints one line per test and a closing count line

`timescale 1ns/1ps
`default_nettype none

module flash_dma_tb;

    localparam int NUM_READS    = 8;
    localparam int BOOT_TIMEOUT = 4000;
    localparam int READ_TIMEOUT = 1000;

    logic                       clk;
    logic                       reset;
    logic                       read_en;
    flash_map_pkg::cpu_addr_t   read_address;
    spi_flash_pkg::flash_word_t read_data;
    logic                       read_ready;
    flash_map_pkg::ram_addr_t   write_address;
    spi_flash_pkg::flash_word_t write_data;
    logic [3:0]                 wstrb;
    logic                       dma_busy;
    logic                       flash_sck;
    logic                       flash_csn;
    logic                       flash_mosi;
    logic                       flash_miso;
    spi_flash_pkg::flash_word_t expected_word;
    int                         error_count;
    int                         check_count;

    // CPU read table holding each offset and the word it must return
    flash_map_pkg::cpu_addr_t   table_offset [NUM_READS];
    spi_flash_pkg::flash_word_t table_word [NUM_READS];

    integer seed;
    int     tests_run;
    int     tests_failed;
    int     errors_before;
    logic   timed_out;

    flash_dma dut (
        .clk           (clk),
        .reset         (reset),
        .read_address  (read_address),
        .read_data     (read_data),
        .read_en       (read_en),
        .read_ready    (read_ready),
        .write_address (write_address),
        .write_data    (write_data),
        .wstrb         (wstrb),
        .dma_busy      (dma_busy),
        .flash_sck     (flash_sck),
        .flash_csn     (flash_csn),
        .flash_mosi    (flash_mosi),
        .flash_miso    (flash_miso)
    );

    spi_flash_model flash (
        .flash_csn  (flash_csn),
        .flash_sck  (flash_sck),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso)
    );

    flash_dma_checker scoreboard (
        .clk           (clk),
        .reset         (reset),
        .dma_busy      (dma_busy),
        .wstrb         (wstrb),
        .write_address (write_address),
        .write_data    (write_data),
        .read_en       (read_en),
        .read_ready    (read_ready),
        .read_data     (read_data),
        .flash_csn     (flash_csn),
        .flash_sck     (flash_sck),
        .expected_word (expected_word),
        .error_count   (error_count),
        .check_count   (check_count)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // little-endian flash word built from the folded byte address xor A5
    function automatic spi_flash_pkg::flash_word_t pattern_word(
        input flash_map_pkg::flash_addr_t a
    );
        spi_flash_pkg::flash_word_t w;
        flash_map_pkg::flash_addr_t b;
        for (int i = 0; i < 4; i++) begin
            b = a + 24'(i);
            w[8*i +: 8] = b[23:16] ^ b[15:8] ^ b[7:0] ^ 8'hA5;
        end
        return w;
    endfunction

    // DUT outputs are polled on the falling edge when they are settled
    task automatic wait_busy_low();
        int cycles;
        cycles = 0;
        while (dma_busy !== 1'b0 && cycles < BOOT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (dma_busy !== 1'b0) begin
            timed_out = 1'b1;
            $display("timeout: dma_busy still high after %0d cycles", BOOT_TIMEOUT);
        end
    endtask

    task automatic wait_read_ready(input string name);
        int cycles;
        cycles = 0;
        while (read_ready !== 1'b1 && cycles < READ_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (read_ready !== 1'b1) begin
            timed_out = 1'b1;
            $display("timeout: no read_ready within %0d cycles in %s", READ_TIMEOUT, name);
        end
    endtask

    // ends on a rising edge so the caller can drive inputs right away
    task automatic report_test(input string name);
        @(posedge clk);
        tests_run++;
        if (timed_out || error_count != errors_before) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
        errors_before = error_count;
    endtask

    initial begin
        reset         = 1'b1;
        read_en       = 1'b0;
        read_address  = '0;
        expected_word = '0;
        seed          = 32'h5bde;
        tests_run     = 0;
        tests_failed  = 0;
        errors_before = 0;
        timed_out     = 1'b0;

        // fixed corner offsets come first and random word-aligned ones after
        table_offset[0] = 18'h00000;
        table_offset[1] = 18'h00004;
        table_offset[2] = 18'h3fffc;
        table_offset[3] = 18'h01230;
        for (int i = 4; i < NUM_READS; i++) begin
            table_offset[i] = 18'($random(seed)) & 18'h3fffc;
        end
        for (int i = 0; i < NUM_READS; i++) begin
            table_word[i] = pattern_word(flash_map_pkg::FLASH_USER_BASE + 24'(table_offset[i]));
        end

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        report_test("reset state");

        for (int i = 0; i < NUM_READS && !timed_out; i++) begin
            read_address  <= table_offset[i];
            expected_word <= table_word[i];
            read_en       <= 1'b1;
            // entry 0 is posted while boot still owns the flash
            if (i == 0) begin
                wait_busy_low();
                report_test("boot copy");
            end
            if (!timed_out) begin
                wait_read_ready($sformatf("read of offset %h", table_offset[i]));
            end
            report_test($sformatf("read %0d offset %h", i, table_offset[i]));
            read_en <= 1'b0;
            @(posedge clk);
        end

        if (!timed_out) begin
            read_address  <= table_offset[1];
            expected_word <= table_word[1];
            read_en       <= 1'b1;
            wait_read_ready("edge detection");
            // read_en stays high for longer than a read so a second pulse would be flagged
            repeat (300) @(posedge clk);
            read_en <= 1'b0;
            report_test("edge detection");
        end

        repeat (20) @(posedge clk);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (!timed_out && tests_failed == 0 && error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/spi_flash_model.sv ====
// behavioral serial flash model for the flash DMA testbench
// supports SPI mode 0 and the plain read command only
// each byte reads back as its three address bytes xored together with 8'hA5
// reading continues at the next byte for as long as chip select stays low

`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
    input  wire logic flash_csn,
    input  wire logic flash_sck,
    input  wire logic flash_mosi,
    output logic      flash_miso
);

    // counts rising sck edges since select up to the end of the header
    logic [5:0]                 bit_index = 6'd0;
    // command byte in the top bits with the 24-bit start address below
    logic [31:0]                header = 32'd0;
    // data position relative to the start address
    flash_map_pkg::flash_addr_t byte_offset = '0;
    logic [2:0]                 bit_pos = 3'd7;
    logic                       miso_bit = 1'b0;
    flash_map_pkg::flash_addr_t byte_addr;
    logic [7:0]                 byte_value;

    assign flash_miso = miso_bit;

    // command and address are sampled MSB first on the rising edge
    always @(posedge flash_sck or posedge flash_csn) begin
        if (flash_csn) begin
            bit_index <= 6'd0;
        end else if (bit_index < 6'd32) begin
            header    <= {header[30:0], flash_mosi};
            bit_index <= bit_index + 6'd1;
        end
    end

    // data is driven on the falling edge starting right after the last address bit
    always @(negedge flash_sck) begin
        if (!flash_csn) begin
            if (bit_index < 6'd32) begin
                byte_offset <= '0;
                bit_pos     <= 3'd7;
            end else begin
                byte_addr  = header[23:0] + byte_offset;
                byte_value = byte_addr[23:16] ^ byte_addr[15:8] ^ byte_addr[7:0] ^ 8'hA5;
                // unknown opcode reads as zeros
                if (header[31:24] != spi_flash_pkg::SPI_READ_CMD) begin
                    byte_value = 8'h00;
                end
                miso_bit <= byte_value[bit_pos];
                bit_pos  <= bit_pos - 3'd1;
                if (bit_pos == 3'd0) begin
                    byte_offset <= byte_offset + 24'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire
